// File: src/dcache_pkg.sv
// shared types and constants for the 4-way write-back data cache
// address is tag[19:10] | set index | byte offset[1:0], one 32-bit word per line
// every file refers to these by dcache_pkg:: scoped names
package dcache_pkg;

    localparam int OFFSET_W        = 2;   // byte offset within the word
    localparam int INDEX_W_DEFAULT = 8;   // 256 sets
    localparam int TAG_W           = 10;
    localparam int ADDR_W          = 20;  // 1 MB byte space
    localparam int WAYS            = 4;   // tied to the 2-bit ages
    localparam int WORD_W          = 32;

    typedef logic [ADDR_W-1:0] addr_t;

    // store size codes
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2,
        SIZE_BAD  = 2'd3   // illegal, access completes with no effect
    } size_e;

    typedef struct packed {
        logic             valid;
        logic             dirty;  // line differs from backing memory
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef tag_entry_t [WAYS-1:0]              tag_set_t;   // 48 bits, one set
    typedef logic [WAYS-1:0][WORD_W-1:0]        data_set_t;  // 128 bits
    typedef logic [WAYS-1:0][1:0]               age_set_t;   // 0 youngest, 3 oldest

    // core side request, strobes sampled only while busy is low
    typedef struct packed {
        logic              read_en;
        logic              write_en;    // wins over read_en if both set
        addr_t             addr;
        logic [WORD_W-1:0] write_data;  // bytes already placed in their lanes
        size_e             store_size;
    } core_req_t;

    // memory side, both strobes are single-cycle pulses
    typedef struct packed {
        logic              fetch_req;
        logic              writeback;
        addr_t             addr;        // word aligned line address
        logic [WORD_W-1:0] data;        // victim word for writeback
    } mem_req_t;

endpackage

// File: src/dcache_way_ram.sv
// generic synchronous RAM, one read port and one write port
// registered read with one cycle latency, output holds while re is low
// element type is a parameter so one module holds data, tag and age sets
`timescale 1ns/1ps

module dcache_way_ram #(
    parameter int  DEPTH_W = 8,
    parameter type elem_t  = logic [31:0]
) (
    input  logic               CLK,
    input  logic               re,
    input  logic [DEPTH_W-1:0] raddr,
    input  logic               we,
    input  logic [DEPTH_W-1:0] waddr,
    input  elem_t              wdata,
    output elem_t              rdata
);

    elem_t mem [0:(1<<DEPTH_W)-1];  // contents undefined until the sweep

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // read during write of the same entry returns the old value
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: src/dcache_lru.sv
// age based replacement for one set of four ways
// picks the victim and computes the ages after a way has been used
// purely combinational, the controller decides when ages_next is written
`timescale 1ns/1ps

module dcache_lru (
    input  dcache_pkg::age_set_t ages,
    input  dcache_pkg::tag_set_t tags,
    input  logic [1:0]           use_way,
    output logic [1:0]           victim,
    output dcache_pkg::age_set_t ages_next
);

    logic [1:0] used_age;  // age of the way being touched

    // victim choice
    always_comb begin
        victim = 2'd0;
        // oldest way first
        for (int w = dcache_pkg::WAYS - 1; w >= 0; w--) begin
            if (ages[w] == 2'd3) begin
                victim = 2'(w);
            end
        end
        // any invalid way overrides, lowest index wins
        for (int w = dcache_pkg::WAYS - 1; w >= 0; w--) begin
            if (!tags[w].valid) begin
                victim = 2'(w);
            end
        end
    end

    assign used_age = ages[use_way];

    // used way becomes youngest, ways younger than it move up by one
    always_comb begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (2'(w) == use_way) begin
                ages_next[w] = 2'd0;
            end else if (ages[w] < used_age) begin
                ages_next[w] = ages[w] + 2'd1;      // cannot pass 3
            end else begin
                ages_next[w] = ages[w];             // older ways keep their age
            end
        end
    end

endmodule

// File: src/dcache_lookup.sv
// hit detection and store merge for the set read from the RAMs
// compares the request tag with every valid way, selects the hit word
// and builds the byte mask that merges store data into that word
`timescale 1ns/1ps

module dcache_lookup (
    input  dcache_pkg::core_req_t          req,
    input  dcache_pkg::tag_set_t           tags,
    input  dcache_pkg::data_set_t          words,
    output logic                           hit,
    output logic [1:0]                     hit_way,
    output logic [dcache_pkg::WORD_W-1:0]  hit_word,
    output logic [dcache_pkg::WORD_W-1:0]  merged,
    output logic                           access_ok
);

    localparam int LANES = dcache_pkg::WORD_W / 8;

    logic [dcache_pkg::TAG_W-1:0]    req_tag;
    logic [dcache_pkg::OFFSET_W-1:0] offset;
    logic [dcache_pkg::WAYS-1:0]     way_match;
    logic [LANES-1:0]                byte_mask;

    assign req_tag = req.addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign offset  = req.addr[dcache_pkg::OFFSET_W-1:0];

    // tag compare on all ways in parallel
    always_comb begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            way_match[w] = tags[w].valid && (tags[w].tag == req_tag);
        end
    end

    assign hit = |way_match;

    always_comb begin
        hit_way = 2'd0;
        for (int w = dcache_pkg::WAYS - 1; w >= 0; w--) begin
            if (way_match[w]) begin
                hit_way = 2'(w);  // at most one match in a sane set
            end
        end
    end

    assign hit_word = words[hit_way];

    // reads are whole words and must be word aligned
    always_comb begin
        access_ok = 1'b0;
        byte_mask = '0;
        if (req.write_en) begin
            case (req.store_size)
                dcache_pkg::SIZE_BYTE: begin
                    access_ok = 1'b1;
                    byte_mask = LANES'(1) << offset;            // lane by offset
                end
                dcache_pkg::SIZE_HALF: begin
                    access_ok = !offset[0];
                    byte_mask = offset[1] ? 4'b1100 : 4'b0011;  // upper or lower half
                end
                dcache_pkg::SIZE_WORD: begin
                    access_ok = (offset == '0);
                    byte_mask = '1;
                end
                default: begin
                    access_ok = 1'b0;                           // SIZE_BAD
                    byte_mask = '0;
                end
            endcase
        end else begin
            access_ok = (offset == '0);
        end
    end

    // byte-wise merge of lane-aligned store data into the hit word
    always_comb begin
        for (int b = 0; b < LANES; b++) begin
            merged[8*b +: 8] = byte_mask[b] ? req.write_data[8*b +: 8] : hit_word[8*b +: 8];
        end
    end

endmodule

// File: src/dcache_ctrl.sv
// cache control FSM: reset sweep, lookup, writeback, refill and replay
// owns the RAM read and write enables and the sweep counter
// a hit finishes in the single LOOKUP cycle, a miss refills and replays
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int INDEX_W = dcache_pkg::INDEX_W_DEFAULT
) (
    input  logic               CLK,
    input  logic               arst_n,
    input  logic               req_start,     // raw strobe from the core
    input  logic               is_write,
    input  logic               hit,
    input  logic               access_ok,
    input  logic               victim_dirty,  // victim valid and dirty
    input  logic               fill_valid,
    output logic               busy,
    output logic               done,
    output logic               sweep,
    output logic [INDEX_W-1:0] sweep_index,
    output logic               re,
    output logic               tag_we,
    output logic               data_we,
    output logic               age_we,
    output logic [1:0]         way_sel,       // {store hit, fill}
    output logic               fetch_req,
    output logic               writeback
);

    typedef enum logic [2:0] {
        SWEEP, IDLE, LOOKUP, WRITEBACK, FETCH, WAIT_FILL, REPLAY
    } state_e;

    state_e             state, state_nxt;
    logic [INDEX_W-1:0] sweep_cnt;
    logic               hit_ok;     // legal access that hit
    logic               store_hit;
    logic               fill_now;

    assign hit_ok    = (state == LOOKUP) && access_ok && hit;
    assign store_hit = hit_ok && is_write;
    assign fill_now  = (state == WAIT_FILL) && fill_valid;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state     <= SWEEP;
            sweep_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == SWEEP) begin
                sweep_cnt <= sweep_cnt + 1'b1;  // one set per cycle
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            SWEEP:     if (sweep_cnt == '1) state_nxt = IDLE;
            IDLE:      if (req_start) state_nxt = LOOKUP;
            LOOKUP: begin
                if (!access_ok || hit) begin
                    state_nxt = IDLE;              // done this cycle
                end else if (victim_dirty) begin
                    state_nxt = WRITEBACK;
                end else begin
                    state_nxt = FETCH;
                end
            end
            WRITEBACK: state_nxt = FETCH;
            FETCH:     state_nxt = WAIT_FILL;
            WAIT_FILL: if (fill_valid) state_nxt = REPLAY;
            REPLAY:    state_nxt = LOOKUP;         // reread after the fill write
            default:   state_nxt = IDLE;
        endcase
    end

    assign busy        = (state != IDLE);
    assign done        = (state == LOOKUP) && (hit || !access_ok);
    assign sweep       = (state == SWEEP);
    assign sweep_index = sweep_cnt;
    // read at acceptance and again on replay, outputs held otherwise
    assign re          = ((state == IDLE) && req_start) || (state == REPLAY);
    assign tag_we      = sweep || store_hit || fill_now;   // sweep clears, hit sets dirty
    assign data_we     = store_hit || fill_now;
    assign age_we      = sweep || hit_ok;
    assign way_sel     = {store_hit, fill_now};
    assign fetch_req   = (state == FETCH);
    assign writeback   = (state == WRITEBACK);

endmodule

// File: src/dcache_top.sv
// top of the 4-way write-back data cache
// registers the accepted core request and connects the set RAMs,
// lookup, LRU and controller; memory side is plain pulses, no handshake
`timescale 1ns/1ps

module dcache_top #(
    parameter int INDEX_W = dcache_pkg::INDEX_W_DEFAULT
) (
    input  logic                          CLK,
    input  logic                          arst_n,
    input  dcache_pkg::core_req_t         req,
    output logic                          busy,
    output logic                          done,
    output logic [dcache_pkg::WORD_W-1:0] rdata,
    output dcache_pkg::mem_req_t          mem,
    input  logic                          fill_valid,
    input  logic [dcache_pkg::WORD_W-1:0] fill_data
);

    dcache_pkg::core_req_t  req_q;          // request under service
    dcache_pkg::tag_set_t   tags, tags_wdata;
    dcache_pkg::data_set_t  words, words_wdata;
    dcache_pkg::age_set_t   ages, ages_next, ages_wdata;
    dcache_pkg::addr_t      line_addr, victim_addr;
    logic [INDEX_W-1:0]     cur_index, raddr, waddr, sweep_index;
    logic [1:0]             hit_way, victim, way_sel, wr_way;
    logic [dcache_pkg::WORD_W-1:0] hit_word, merged;
    logic req_start, hit, access_ok, victim_dirty, sweep, re;
    logic tag_we, data_we, age_we, fetch_req, writeback;

    assign req_start = req.read_en || req.write_en;

    always_ff @(posedge CLK) begin
        if (req_start && !busy) begin
            req_q <= req;                   // accepted only while idle
        end
    end

    assign cur_index = req_q.addr[dcache_pkg::OFFSET_W +: INDEX_W];
    assign raddr     = busy ? cur_index : req.addr[dcache_pkg::OFFSET_W +: INDEX_W];
    assign waddr     = sweep ? sweep_index : cur_index;
    assign wr_way    = way_sel[0] ? victim : hit_way;  // fill targets the victim

    always_comb begin
        tags_wdata = tags;
        if (sweep) begin
            tags_wdata = '0;                            // all ways invalid
        end else if (way_sel[0]) begin
            tags_wdata[victim].valid = 1'b1;            // refilled line is clean
            tags_wdata[victim].dirty = 1'b0;
            tags_wdata[victim].tag   = req_q.addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
        end else if (way_sel[1]) begin
            tags_wdata[hit_way].dirty = 1'b1;
        end
        words_wdata         = words;
        words_wdata[wr_way] = way_sel[0] ? fill_data : merged;
        ages_wdata          = sweep ? 8'b11_10_01_00 : ages_next;  // way 0 youngest
    end

    // line addresses for the miss and for the victim
    always_comb begin
        line_addr   = '0;
        victim_addr = '0;
        line_addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W] =
            req_q.addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
        line_addr[dcache_pkg::OFFSET_W +: INDEX_W]            = cur_index;
        victim_addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W] = tags[victim].tag;
        victim_addr[dcache_pkg::OFFSET_W +: INDEX_W]            = cur_index;
    end

    assign victim_dirty  = tags[victim].valid && tags[victim].dirty;
    assign rdata         = hit_word;
    assign mem.fetch_req = fetch_req;
    assign mem.writeback = writeback;
    assign mem.addr      = writeback ? victim_addr : line_addr;
    assign mem.data      = words[victim];

    dcache_way_ram #(.DEPTH_W(INDEX_W), .elem_t(dcache_pkg::data_set_t)) u_data_ram (
        .CLK(CLK), .re(re), .raddr(raddr), .we(data_we), .waddr(waddr),
        .wdata(words_wdata), .rdata(words));

    dcache_way_ram #(.DEPTH_W(INDEX_W), .elem_t(dcache_pkg::tag_set_t)) u_tag_ram (
        .CLK(CLK), .re(re), .raddr(raddr), .we(tag_we), .waddr(waddr),
        .wdata(tags_wdata), .rdata(tags));

    dcache_way_ram #(.DEPTH_W(INDEX_W), .elem_t(dcache_pkg::age_set_t)) u_age_ram (
        .CLK(CLK), .re(re), .raddr(raddr), .we(age_we), .waddr(waddr),
        .wdata(ages_wdata), .rdata(ages));

    dcache_lookup u_lookup (
        .req(req_q), .tags(tags), .words(words), .hit(hit), .hit_way(hit_way),
        .hit_word(hit_word), .merged(merged), .access_ok(access_ok));

    dcache_lru u_lru (
        .ages(ages), .tags(tags), .use_way(hit_way), .victim(victim), .ages_next(ages_next));

    dcache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (
        .CLK(CLK), .arst_n(arst_n), .req_start(req_start), .is_write(req_q.write_en),
        .hit(hit), .access_ok(access_ok), .victim_dirty(victim_dirty),
        .fill_valid(fill_valid), .busy(busy), .done(done), .sweep(sweep),
        .sweep_index(sweep_index), .re(re), .tag_we(tag_we), .data_we(data_we),
        .age_we(age_we), .way_sel(way_sel), .fetch_req(fetch_req), .writeback(writeback));

endmodule

// File: verif/dcache_properties.sv
// protocol checks on the cache memory side and on busy/done, bound into dcache_top
// failures raise $error and bump fail_cnt, which the testbench watches
`timescale 1ns/1ps

module dcache_properties (
    input logic                 CLK,
    input logic                 arst_n,
    input logic                 busy,
    input logic                 done,
    input dcache_pkg::mem_req_t mem
);

    int unsigned fail_cnt = 0;  // count of failed checks

    a_no_overlap: assert property (@(posedge CLK) disable iff (!arst_n)
        !(mem.fetch_req && mem.writeback))
        else begin
            $error("fetch_req and writeback high in the same cycle");
            fail_cnt++;
        end

    a_wb_then_fetch: assert property (@(posedge CLK) disable iff (!arst_n)
        mem.writeback |=> mem.fetch_req)  // refill follows the victim writeback
        else begin
            $error("writeback not followed by fetch_req");
            fail_cnt++;
        end

    a_done_pulse: assert property (@(posedge CLK) disable iff (!arst_n)
        done |=> !done)
        else begin
            $error("done longer than one cycle");
            fail_cnt++;
        end

    a_idle_after_done: assert property (@(posedge CLK) disable iff (!arst_n)
        done |=> !busy)  // back in idle right after completion
        else begin
            $error("busy still high in the cycle after done");
            fail_cnt++;
        end

endmodule

bind dcache_top dcache_properties u_props (
    .CLK(CLK), .arst_n(arst_n), .busy(busy), .done(done), .mem(mem));

// File: verif/tb_dcache.sv
// testbench for the 4-way write-back data cache
// drives directed and random core accesses, answers refills from a backing memory
// and checks rdata and memory-side traffic against a reference model with assertions
`timescale 1ns/1ps

module tb_dcache;

    localparam int INDEX_W  = dcache_pkg::INDEX_W_DEFAULT;
    localparam int SETS     = 1 << INDEX_W;
    localparam int N_RANDOM = 64;
    localparam int N_OPS    = 40 + N_RANDOM;            // directed ops stay under 40
    localparam int LIMIT    = N_OPS * 16 + SETS + 10;   // accesses, sweep and reset

    logic                  CLK, arst_n, fill_valid, busy, done, accept;
    logic [31:0]           fill_data, rdata;
    dcache_pkg::core_req_t req;
    dcache_pkg::mem_req_t  mem;

    logic [31:0] backing [0:(1<<18)-1];  // responder memory, written by writebacks
    logic [31:0] ref_mem [0:(1<<18)-1];  // model view of memory
    logic        m_valid [SETS][4];
    logic        m_dirty [SETS][4];
    logic [9:0]  m_tag   [SETS][4];
    logic [31:0] m_data  [SETS][4];
    logic [1:0]  m_age   [SETS][4];      // 0 youngest

    logic        exp_miss, exp_wb, exp_rd;
    logic [19:0] exp_line, exp_wb_addr;
    logic [31:0] exp_wb_data, exp_rdata;
    string       test_name;
    integer      seed = 32'he4e;
    int unsigned fetch_cnt = 0;
    int unsigned wb_cnt = 0;
    int unsigned cycles = 0;

    dcache_top #(.INDEX_W(INDEX_W)) u_dut (
        .CLK(CLK), .arst_n(arst_n), .req(req), .busy(busy), .done(done), .rdata(rdata),
        .mem(mem), .fill_valid(fill_valid), .fill_data(fill_data));

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic logic [31:0] pattern(input logic [17:0] word);
        return {~word[13:0], word};  // every word address gives its own value
    endfunction

    function automatic logic [19:0] addr_of(input int tag, input int set, input int off);
        return {10'(tag), INDEX_W'(set), 2'(off)};
    endfunction

    // model of one access: sets the expectations, then updates tags, ages and data
    task automatic predict(input logic wr, input logic [19:0] a, input logic [31:0] wd,
                           input logic [1:0] size);
        int         s, way, w, b;
        logic       ok;
        logic [3:0] mask;
        s    = a[2 +: INDEX_W];
        ok   = wr ? (size == 0 || (size == 1 && !a[0]) || (size == 2 && a[1:0] == 0))
                  : (a[1:0] == 0);
        mask = (size == 0) ? 4'b0001 << a[1:0] : (size == 1) ? (a[1] ? 4'hc : 4'h3) : 4'hf;
        exp_miss = 0;
        exp_wb   = 0;
        exp_rd   = !wr && ok;
        if (!ok) return;                                 // no effect at all
        way = -1;
        for (w = 3; w >= 0; w--) begin
            if (m_valid[s][w] && m_tag[s][w] == a[19:10]) way = w;
        end
        if (way < 0) begin
            exp_miss = 1;
            exp_line = {a[19:2], 2'b00};
            for (w = 0; w < 4; w++) if (m_age[s][w] == 3) way = w;      // oldest
            for (w = 3; w >= 0; w--) if (!m_valid[s][w]) way = w;      // free way first
            if (m_valid[s][way] && m_dirty[s][way]) begin
                exp_wb      = 1;
                exp_wb_addr = {m_tag[s][way], a[2 +: INDEX_W], 2'b00};
                exp_wb_data = m_data[s][way];
                ref_mem[{m_tag[s][way], a[2 +: INDEX_W]}] = m_data[s][way];
            end
            m_valid[s][way] = 1;
            m_dirty[s][way] = 0;
            m_tag[s][way]   = a[19:10];
            m_data[s][way]  = ref_mem[a[19:2]];
        end
        for (w = 0; w < 4; w++) begin
            if (w != way && m_age[s][w] < m_age[s][way]) m_age[s][w] = m_age[s][w] + 1;
        end
        m_age[s][way] = 0;
        if (wr) begin
            for (b = 0; b < 4; b++) if (mask[b]) m_data[s][way][8*b +: 8] = wd[8*b +: 8];
            m_dirty[s][way] = 1;
        end
        exp_rdata = m_data[s][way];
    endtask

    // one core access, strobe for a cycle, then wait for done
    task automatic access(input logic wr, input logic [19:0] a, input logic [31:0] wd,
                          input logic [1:0] size);
        predict(wr, a, wd, size);
        req.read_en    = !wr;
        req.write_en   = wr;
        req.addr       = a;
        req.write_data = wd;
        req.store_size = dcache_pkg::size_e'(size);
        @(posedge CLK);
        #1;
        req.read_en  = 0;
        req.write_en = 0;
        while (!done) begin
            @(posedge CLK);
            #1;
        end
        @(posedge CLK);  // let the done cycle be sampled
        #1;
    endtask

    initial begin
        CLK = 0;
        forever #50 CLK = ~CLK;
    end

    assign accept = (req.read_en || req.write_en) && !busy;

    always @(posedge CLK) begin
        if (accept) begin
            fetch_cnt <= 0;
            wb_cnt    <= 0;
        end else begin
            fetch_cnt <= fetch_cnt + mem.fetch_req;
            wb_cnt    <= wb_cnt + mem.writeback;
        end
        cycles <= cycles + 1;
        if (cycles >= LIMIT) abort_run("timeout: cache did not finish within the cycle limit");
    end

    always @(negedge CLK) begin
        if (u_dut.u_props.fail_cnt != 0) abort_run("a bound protocol assertion failed");
    end

    // backing memory, refill after 1 to 8 cycles
    initial begin : responder
        int unsigned delay;
        logic [17:0] line;
        forever begin
            @(posedge CLK);
            #1;
            if (mem.writeback) backing[mem.addr[19:2]] = mem.data;
            if (mem.fetch_req) begin
                line  = mem.addr[19:2];
                delay = 1 + {$random(seed)} % 8;
                repeat (delay) @(posedge CLK);
                #1;
                fill_valid = 1;
                fill_data  = backing[line];
                @(posedge CLK);
                #1;
                fill_valid = 0;
            end
        end
    end

    a_rdata: assert property (@(posedge CLK) disable iff (!arst_n)
        done && exp_rd |-> rdata == exp_rdata)
        else abort_run($sformatf("FAILED %s: rdata expected %h actual %h",
                                 test_name, $sampled(exp_rdata), $sampled(rdata)));

    a_fetch_addr: assert property (@(posedge CLK) disable iff (!arst_n)
        mem.fetch_req |-> mem.addr == exp_line)
        else abort_run($sformatf("FAILED %s: fetch address expected %h actual %h",
                                 test_name, $sampled(exp_line), $sampled(mem.addr)));

    a_wb_addr: assert property (@(posedge CLK) disable iff (!arst_n)
        mem.writeback |-> mem.addr == exp_wb_addr)
        else abort_run($sformatf("FAILED %s: writeback address expected %h actual %h",
                                 test_name, $sampled(exp_wb_addr), $sampled(mem.addr)));

    a_wb_data: assert property (@(posedge CLK) disable iff (!arst_n)
        mem.writeback |-> mem.data == exp_wb_data)
        else abort_run($sformatf("FAILED %s: writeback data expected %h actual %h",
                                 test_name, $sampled(exp_wb_data), $sampled(mem.data)));

    a_fetch_cnt: assert property (@(posedge CLK) disable iff (!arst_n)
        done |-> fetch_cnt == exp_miss)
        else abort_run($sformatf("FAILED %s: fetch_req count expected %0d actual %0d",
                                 test_name, $sampled(exp_miss), $sampled(fetch_cnt)));

    a_wb_cnt: assert property (@(posedge CLK) disable iff (!arst_n)
        done |-> wb_cnt == exp_wb)
        else abort_run($sformatf("FAILED %s: writeback count expected %0d actual %0d",
                                 test_name, $sampled(exp_wb), $sampled(wb_cnt)));

    a_fast_done: assert property (@(posedge CLK) disable iff (!arst_n)
        accept && !exp_miss |=> done)  // hits and illegal accesses take one cycle
        else abort_run($sformatf("FAILED %s: done after acceptance expected 1 actual %0d",
                                 test_name, $sampled(done)));

    initial begin
        int          i, s, w, t, r_tag, r_set, r_off, sweep_len;
        logic        r_wr;
        logic [1:0]  r_size;
        logic [31:0] r_data;
        req         = '0;
        fill_valid  = 0;
        fill_data   = '0;
        arst_n      = 0;
        test_name   = "reset";
        exp_miss    = 0;
        exp_wb      = 0;
        exp_rd      = 0;
        exp_line    = '0;
        exp_wb_addr = '0;
        exp_wb_data = '0;
        exp_rdata   = '0;
        for (i = 0; i < (1 << 18); i++) begin
            backing[i] = pattern(18'(i));
            ref_mem[i] = pattern(18'(i));
        end
        for (s = 0; s < SETS; s++) begin
            for (w = 0; w < 4; w++) begin
                m_valid[s][w] = 0;
                m_dirty[s][w] = 0;
                m_tag[s][w]   = '0;
                m_data[s][w]  = '0;
                m_age[s][w]   = 2'(w);  // sweep leaves way 0 youngest
            end
        end
        repeat (10) @(posedge CLK);
        #1;
        arst_n    = 1;
        sweep_len = 0;
        while (busy) begin              // tag sweep, one set per cycle
            assert (!done && !mem.fetch_req && !mem.writeback)
                else abort_run("done or a memory strobe was raised during the reset sweep");
            @(posedge CLK);
            #1;
            sweep_len++;
        end
        assert (sweep_len == SETS)
            else abort_run($sformatf("FAILED %s: sweep cycles expected %0d actual %0d",
                                     test_name, SETS, sweep_len));

        test_name = "cold_read";
        access(0, addr_of(1, 5, 0), 0, 2);
        test_name = "hit_read";
        access(0, addr_of(1, 5, 0), 0, 2);

        test_name = "sub_word_stores";
        access(1, addr_of(1, 5, 1), 32'h0000_ab00, 0);
        access(1, addr_of(1, 5, 2), 32'hcdef_0000, 1);
        access(0, addr_of(1, 5, 0), 0, 2);
        access(1, addr_of(2, 5, 3), 32'h5a00_0000, 0);  // store miss, allocate first
        access(0, addr_of(2, 5, 0), 0, 2);
        access(1, addr_of(2, 5, 0), 32'h1234_5678, 2);
        access(0, addr_of(2, 5, 0), 0, 2);

        test_name = "illegal_access";
        access(1, addr_of(1, 5, 0), 32'hffff_ffff, 3);
        access(1, addr_of(1, 5, 2), 32'hffff_ffff, 2);
        access(1, addr_of(1, 5, 1), 32'hffff_ffff, 1);
        access(1, addr_of(7, 5, 0), 32'hffff_ffff, 3);  // would miss, still no fetch
        access(0, addr_of(7, 5, 2), 0, 2);
        access(0, addr_of(1, 5, 0), 0, 2);

        test_name = "evict_dirty";
        for (t = 1; t <= 4; t++) access(0, addr_of(t, 9, 0), 0, 2);
        access(1, addr_of(1, 9, 0), 32'hdead_beef, 2);
        for (t = 2; t <= 4; t++) access(0, addr_of(t, 9, 0), 0, 2);
        access(0, addr_of(5, 9, 0), 0, 2);              // tag 1 oldest and dirty
        access(0, addr_of(1, 9, 0), 0, 2);              // back from memory

        test_name = "lru_protect";
        for (t = 1; t <= 4; t++) access(0, addr_of(t, 12, 0), 0, 2);
        access(0, addr_of(1, 12, 0), 0, 2);             // way 0 made youngest
        access(0, addr_of(5, 12, 0), 0, 2);             // tag 2 goes instead
        access(0, addr_of(1, 12, 0), 0, 2);
        access(0, addr_of(2, 12, 0), 0, 2);

        test_name = "random_mix";
        for (i = 0; i < N_RANDOM; i++) begin
            r_wr   = $random(seed) & 1;
            r_tag  = {$random(seed)} % 6;
            r_set  = 3 + {$random(seed)} % 2;
            r_off  = ($random(seed) & 1) ? 0 : {$random(seed)} % 4;  // mostly aligned
            r_data = $random(seed);
            r_size = {$random(seed)} % 4;
            access(r_wr, addr_of(r_tag, r_set, r_off), r_data, r_size);
        end

        if (u_dut.u_props.fail_cnt != 0) begin
            abort_run("a bound protocol assertion failed");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: filelist.f
src/dcache_pkg.sv
src/dcache_way_ram.sv
src/dcache_lru.sv
src/dcache_lookup.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verif/dcache_properties.sv
verif/tb_dcache.sv
